/* Makefile */
VERILATOR ?= verilator
TOP       ?= alu_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi
	@if ! grep -q "TEST OK" $(LOG); then \
		echo "simulation did not finish cleanly"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* compile.f */
verilog/alu_pkg.sv
verilog/arith_logic_unit.sv
verilog/bit_shift_unit.sv
verilog/alu_result_reg.sv
verilog/tlcs_alu.sv
verif/alu_asserts.sv
verif/alu_checker.sv
verif/alu_tb.sv

/* verif/alu_asserts.sv */
module alu_asserts (
    input logic                        clk,
    input logic                        rst,
    input logic                        op_valid,
    input logic [alu_pkg::WIDTH_W-1:0] width,
    input logic [alu_pkg::DATA_W-1:0]  dout,
    input logic [alu_pkg::FLAG_W-1:0]  flags,
    input logic                        result_we
);
    timeunit 1ns;
    timeprecision 1ps;

    import alu_pkg::*;

    int n_errors = 0;

    reset_zero_a: assert property (@(posedge clk)
        rst |-> (dout == '0 && flags == '0 && !result_we))
        else begin
            n_errors++;
            $error("outputs not zero during reset");
        end

    // bits 5 and 3 are unused in the flag byte
    flag_gap_a: assert property (@(posedge clk) disable iff (rst)
        flags[5] == 1'b0 && flags[3] == 1'b0)
        else begin
            n_errors++;
            $error("unused flag bit set");
        end

    we_cause_a: assert property (@(posedge clk) disable iff (rst)
        !(op_valid && width != WIDTH_IDLE) |=> !result_we)
        else begin
            n_errors++;
            $error("result_we without a valid operation");
        end

endmodule

bind tlcs_alu alu_asserts asserts_i (
    .clk       (clk),
    .rst       (rst),
    .op_valid  (op_valid),
    .width     (width),
    .dout      (dout),
    .flags     (flags),
    .result_we (result_we)
);

/* verif/alu_checker.sv */
module alu_checker (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        op_valid,
    input  int                          row_idx,
    input  logic [alu_pkg::DATA_W-1:0]  exp_dout,
    input  logic [alu_pkg::FLAG_W-1:0]  exp_flags,
    input  logic                        exp_we,
    input  logic [alu_pkg::DATA_W-1:0]  dout,
    input  logic [alu_pkg::FLAG_W-1:0]  flags,
    input  logic                        result_we,
    output int                          n_checked,
    output int                          n_failed
);
    timeunit 1ns;
    timeprecision 1ps;

    import alu_pkg::*;

    logic                pend;
    int                  pend_row;
    logic [DATA_W-1:0]   pend_dout;
    logic [FLAG_W-1:0]   pend_flags;
    logic                pend_we;
    logic                reset_done;

    // capture the row on the edge where the DUT loads it
    always @(posedge clk) begin
        pend       <= !rst && op_valid;
        pend_row   <= row_idx;
        pend_dout  <= exp_dout;
        pend_flags <= exp_flags;
        pend_we    <= exp_we;
    end

    initial begin
        n_checked  = 0;
        n_failed   = 0;
        reset_done = 1'b0;
    end

    // outputs are settled at the falling edge
    always @(negedge clk) begin
        if (!rst && !reset_done) begin
            reset_done = 1'b1;
            n_checked++;
            if (dout !== '0 || flags !== '0 || result_we !== 1'b0) begin
                n_failed++;
                $display("FAIL @ %0t: after reset dout=%h flags=%h result_we=%b, want zeros",
                         $time, dout, flags, result_we);
            end else begin
                $display("PASS reset values");
            end
        end
        if (pend) begin
            n_checked++;
            if (dout !== pend_dout || flags !== pend_flags || result_we !== pend_we) begin
                n_failed++;
                $display("FAIL @ %0t: row %0d dout=%h/%h flags=%h/%h result_we=%b/%b (got/exp)",
                         $time, pend_row, dout, pend_dout, flags, pend_flags,
                         result_we, pend_we);
            end else begin
                $display("PASS row %0d", pend_row);
            end
        end
    end

endmodule

/* verif/alu_tb.sv */
module alu_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import alu_pkg::*;

    localparam int N_ROWS   = 39;
    localparam int TIMEOUT  = 1000;    // cycles
    localparam int SEED     = 32'hc74a;
    localparam int MAX_IDLE = 4;

    logic                 clk;
    logic                 rst;
    logic                 op_valid;
    alu_op_e              op;
    logic [WIDTH_W-1:0]   width;
    logic [DATA_W-1:0]    op0;
    logic [DATA_W-1:0]    op1;
    logic [DATA_W-1:0]    dout;
    logic [FLAG_W-1:0]    flags;
    logic                 result_we;

    logic [DATA_W-1:0]    exp_dout;
    logic [FLAG_W-1:0]    exp_flags;
    logic                 exp_we;
    int                   row_idx;
    int                   n_checked;
    int                   n_failed;

    alu_op_e              tab_op    [N_ROWS];
    logic [WIDTH_W-1:0]   tab_width [N_ROWS];
    logic [DATA_W-1:0]    tab_op0   [N_ROWS];
    logic [DATA_W-1:0]    tab_op1   [N_ROWS];
    logic [DATA_W-1:0]    tab_dout  [N_ROWS];
    logic [FLAG_W-1:0]    tab_flags [N_ROWS];
    logic                 tab_we    [N_ROWS];

    tlcs_alu dut_i (
        .clk       (clk),
        .rst       (rst),
        .op_valid  (op_valid),
        .op        (op),
        .width     (width),
        .op0       (op0),
        .op1       (op1),
        .dout      (dout),
        .flags     (flags),
        .result_we (result_we)
    );

    alu_checker checker_i (
        .clk       (clk),
        .rst       (rst),
        .op_valid  (op_valid),
        .row_idx   (row_idx),
        .exp_dout  (exp_dout),
        .exp_flags (exp_flags),
        .exp_we    (exp_we),
        .dout      (dout),
        .flags     (flags),
        .result_we (result_we),
        .n_checked (n_checked),
        .n_failed  (n_failed)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic set_row(input int i, input alu_op_e o, input logic [WIDTH_W-1:0] w,
                           input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b,
                           input logic [DATA_W-1:0] d, input logic [FLAG_W-1:0] f,
                           input logic we);
        tab_op[i]    = o;
        tab_width[i] = w;
        tab_op0[i]   = a;
        tab_op1[i]   = b;
        tab_dout[i]  = d;
        tab_flags[i] = f;
        tab_we[i]    = we;
    endtask

    // flag weights S=80 Z=40 H=10 V=04 N=02 C=01
    // each row sees the flags left by the row before
    task automatic fill_table();
        set_row(0,  OP_ADD,   WIDTH_BYTE, 32'h80,        32'h80,       32'h100,       8'h45, 1);
        set_row(1,  OP_ADC,   WIDTH_BYTE, 32'h10,        32'h05,       32'h16,        8'h00, 1);
        set_row(2,  OP_SUB,   WIDTH_WORD, 32'h1000,      32'h1,        32'h0fff,      8'h12, 1);
        set_row(3,  OP_SUB,   WIDTH_LONG, 32'h0,         32'h1,        32'hffff_ffff, 8'h93, 1);
        set_row(4,  OP_SBC,   WIDTH_LONG, 32'h5,         32'h2,        32'h2,         8'h02, 1);
        set_row(5,  OP_CP,    WIDTH_BYTE, 32'h42,        32'h42,       32'h2,         8'h42, 0);
        set_row(6,  OP_ADD,   WIDTH_WORD, 32'h7fff,      32'h1,        32'h8000,      8'h94, 1);
        set_row(7,  OP_ADD,   WIDTH_LONG, 32'hffff_ffff, 32'h1,        32'h0,         8'h51, 1);
        set_row(8,  OP_INC,   WIDTH_BYTE, 32'h7f,        32'h1,        32'h80,        8'h95, 1);
        set_row(9,  OP_DEC,   WIDTH_BYTE, 32'h1,         32'h1,        32'h0,         8'h43, 1);
        set_row(10, OP_INC,   WIDTH_WORD, 32'hffff,      32'h1,        32'h1_0000,    8'h43, 1);
        set_row(11, OP_DEC,   WIDTH_WORD, 32'h0,         32'h2,        32'hffff_fffe, 8'h43, 1);
        set_row(12, OP_AND,   WIDTH_BYTE, 32'hf0,        32'h3c,       32'h30,        8'h14, 1);
        set_row(13, OP_OR,    WIDTH_WORD, 32'h8000,      32'h1,        32'h8001,      8'h84, 1);
        set_row(14, OP_XOR,   WIDTH_LONG, 32'h1234_5678, 32'h1234_5678, 32'h0,        8'h44, 1);
        set_row(15, OP_XOR,   WIDTH_BYTE, 32'h1,         32'h0,        32'h1,         8'h00, 1);
        set_row(16, OP_RLC,   WIDTH_BYTE, 32'h81,        32'h0,        32'h3,         8'h05, 1);
        set_row(17, OP_RRC,   WIDTH_BYTE, 32'h1,         32'h0,        32'h80,        8'h81, 1);
        set_row(18, OP_RL,    WIDTH_BYTE, 32'h40,        32'h0,        32'h81,        8'h84, 1);
        set_row(19, OP_RR,    WIDTH_WORD, 32'h1,         32'h0,        32'h0,         8'h45, 1);
        set_row(20, OP_SLA,   WIDTH_LONG, 32'h8000_0001, 32'h0,        32'h2,         8'h01, 1);
        set_row(21, OP_SRA,   WIDTH_BYTE, 32'h1234_5680, 32'h0,        32'h1234_56c0, 8'h84, 1);
        set_row(22, OP_SRL,   WIDTH_WORD, 32'h3,         32'h0,        32'h1,         8'h01, 1);
        set_row(23, OP_BIT,   WIDTH_LONG, 32'h20,        32'h5,        32'h1,         8'h11, 0);
        set_row(24, OP_BIT,   WIDTH_WORD, 32'h20,        32'h4,        32'h1,         8'h51, 0);
        set_row(25, OP_SET,   WIDTH_WORD, 32'h0,         32'hf,        32'h8000,      8'h51, 1);
        set_row(26, OP_RES,   WIDTH_LONG, 32'hffff_ffff, 32'h0,        32'hffff_fffe, 8'h51, 1);
        set_row(27, OP_CHG,   WIDTH_BYTE, 32'ha5,        32'h2,        32'ha1,        8'h51, 1);
        set_row(28, OP_TSET,  WIDTH_BYTE, 32'h18,        32'h3,        32'h18,        8'h11, 1);
        set_row(29, OP_RCF,   WIDTH_BYTE, 32'h0,         32'h0,        32'h18,        8'h00, 0);
        set_row(30, OP_SCF,   WIDTH_BYTE, 32'h0,         32'h0,        32'h18,        8'h01, 0);
        set_row(31, OP_CCF,   WIDTH_BYTE, 32'h0,         32'h0,        32'h18,        8'h00, 0);
        set_row(32, OP_ZCF,   WIDTH_BYTE, 32'h0,         32'h0,        32'h18,        8'h01, 0);
        set_row(33, OP_LDCF,  WIDTH_BYTE, 32'h4,         32'h3,        32'h18,        8'h00, 0);
        set_row(34, OP_ORCF,  WIDTH_BYTE, 32'h4,         32'h2,        32'h18,        8'h01, 0);
        set_row(35, OP_ANDCF, WIDTH_BYTE, 32'h4,         32'h0,        32'h18,        8'h00, 0);
        set_row(36, OP_XORCF, WIDTH_WORD, 32'h8000,      32'hf,        32'h18,        8'h01, 0);
        set_row(37, OP_ADC,   WIDTH_BYTE, 32'hff,        32'h0,        32'h100,       8'h51, 1);
        set_row(38, OP_ADD,   WIDTH_IDLE, 32'h5,         32'h5,        32'h100,       8'h51, 0);
    endtask

    initial begin
        int idle;
        int cycles;
        logic timed_out;

        rst       = 1'b1;
        op_valid  = 1'b0;
        op        = OP_ADD;
        width     = WIDTH_IDLE;
        op0       = '0;
        op1       = '0;
        exp_dout  = '0;
        exp_flags = '0;
        exp_we    = 1'b0;
        row_idx   = 0;
        timed_out = 1'b0;
        void'($urandom(SEED));
        fill_table();

        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        for (int i = 0; i < N_ROWS; i++) begin
            idle = int'($urandom % MAX_IDLE);    // zero gives back-to-back rows
            for (int k = 0; k < idle; k++) begin
                @(posedge clk);
                op_valid <= 1'b0;
            end
            @(posedge clk);
            op_valid  <= 1'b1;
            op        <= tab_op[i];
            width     <= tab_width[i];
            op0       <= tab_op0[i];
            op1       <= tab_op1[i];
            exp_dout  <= tab_dout[i];
            exp_flags <= tab_flags[i];
            exp_we    <= tab_we[i];
            row_idx   <= i;
        end
        @(posedge clk);
        op_valid <= 1'b0;

        // reset check plus one per row
        cycles = 0;
        while (n_checked < N_ROWS + 1 && cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (n_checked < N_ROWS + 1) begin
            $display("timeout: the checker reported only %0d of %0d results",
                     n_checked, N_ROWS + 1);
            timed_out = 1'b1;
        end

        $display("tests: %0d checked, %0d passed, %0d failed, %0d assertion failures",
                 n_checked, n_checked - n_failed, n_failed, dut_i.asserts_i.n_errors);
        if (timed_out || n_failed != 0 || dut_i.asserts_i.n_errors != 0) begin
            $display("TEST FAILED");
        end else begin
            $display("TEST OK");
        end
        $finish;
    end

endmodule

/* verilog/alu_pkg.sv */
package alu_pkg;

    localparam int DATA_W    = 32;
    localparam int FLAG_W    = 8;
    localparam int BIT_IDX_W = 4;
    localparam int WIDTH_W   = 2;

    // packed flag byte, bits 5 and 3 read zero
    localparam int FLAG_S_BIT = 7;
    localparam int FLAG_Z_BIT = 6;
    localparam int FLAG_H_BIT = 4;
    localparam int FLAG_V_BIT = 2;
    localparam int FLAG_N_BIT = 1;
    localparam int FLAG_C_BIT = 0;

    localparam logic [WIDTH_W-1:0] WIDTH_IDLE = 2'd0;
    localparam logic [WIDTH_W-1:0] WIDTH_BYTE = 2'd1;
    localparam logic [WIDTH_W-1:0] WIDTH_WORD = 2'd2;
    localparam logic [WIDTH_W-1:0] WIDTH_LONG = 2'd3;

    typedef enum logic [5:0] {
        OP_ADD   = 6'd0,
        OP_ADC   = 6'd1,
        OP_SUB   = 6'd2,
        OP_SBC   = 6'd3,
        OP_CP    = 6'd4,
        OP_INC   = 6'd5,
        OP_DEC   = 6'd6,
        OP_AND   = 6'd7,
        OP_OR    = 6'd8,
        OP_XOR   = 6'd9,
        // one-bit shifts and rotates
        OP_RLC   = 6'd16,
        OP_RRC   = 6'd17,
        OP_RL    = 6'd18,
        OP_RR    = 6'd19,
        OP_SLA   = 6'd20,
        OP_SRA   = 6'd21,
        OP_SRL   = 6'd22,
        // indexed bit operations
        OP_BIT   = 6'd32,
        OP_SET   = 6'd33,
        OP_RES   = 6'd34,
        OP_CHG   = 6'd35,
        OP_TSET  = 6'd36,
        // carry flag operations
        OP_SCF   = 6'd48,
        OP_RCF   = 6'd49,
        OP_CCF   = 6'd50,
        OP_ZCF   = 6'd51,
        OP_LDCF  = 6'd52,
        OP_ANDCF = 6'd53,
        OP_ORCF  = 6'd54,
        OP_XORCF = 6'd55
    } alu_op_e;

endpackage

/* verilog/alu_result_reg.sv */
module alu_result_reg (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         op_valid,
    input  logic [alu_pkg::WIDTH_W-1:0]  width,
    input  logic                         al_claim,
    input  logic                         al_write,
    input  logic [alu_pkg::DATA_W-1:0]   al_result,
    input  logic [alu_pkg::FLAG_W-1:0]   al_flags,
    input  logic                         bs_claim,
    input  logic                         bs_write,
    input  logic [alu_pkg::DATA_W-1:0]   bs_result,
    input  logic [alu_pkg::FLAG_W-1:0]   bs_flags,
    output logic [alu_pkg::DATA_W-1:0]   dout,
    output logic [alu_pkg::FLAG_W-1:0]   flags,
    output logic                         result_we
);
    import alu_pkg::*;

    logic                load;
    logic                sel_write;
    logic [DATA_W-1:0]   sel_result;
    logic [FLAG_W-1:0]   sel_flags;
    logic                s_q, z_q, h_q, v_q, n_q, c_q;

    // the units never claim the same opcode
    assign sel_write  = al_claim ? al_write  : bs_write;
    assign sel_result = al_claim ? al_result : bs_result;
    assign sel_flags  = al_claim ? al_flags  : bs_flags;

    assign load = op_valid && (width != WIDTH_IDLE) && (al_claim || bs_claim);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s_q <= 1'b0;
            z_q <= 1'b0;
            h_q <= 1'b0;
            v_q <= 1'b0;
            n_q <= 1'b0;
            c_q <= 1'b0;
        end else if (load) begin
            s_q <= sel_flags[FLAG_S_BIT];
            z_q <= sel_flags[FLAG_Z_BIT];
            h_q <= sel_flags[FLAG_H_BIT];
            v_q <= sel_flags[FLAG_V_BIT];
            n_q <= sel_flags[FLAG_N_BIT];
            c_q <= sel_flags[FLAG_C_BIT];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dout      <= '0;
            result_we <= 1'b0;
        end else begin
            result_we <= load && sel_write;    // one-cycle strobe
            if (load && sel_write) begin
                dout <= sel_result;
            end
        end
    end

    always_comb begin
        flags             = '0;     // unused bits stay low
        flags[FLAG_S_BIT] = s_q;
        flags[FLAG_Z_BIT] = z_q;
        flags[FLAG_H_BIT] = h_q;
        flags[FLAG_V_BIT] = v_q;
        flags[FLAG_N_BIT] = n_q;
        flags[FLAG_C_BIT] = c_q;
    end

endmodule

/* verilog/arith_logic_unit.sv */
module arith_logic_unit (
    input  alu_pkg::alu_op_e             op,
    input  logic [alu_pkg::WIDTH_W-1:0]  width,
    input  logic [alu_pkg::DATA_W-1:0]   op0,    // destination
    input  logic [alu_pkg::DATA_W-1:0]   op1,    // source
    input  logic [alu_pkg::FLAG_W-1:0]   flags_q,
    output logic                         al_claim,
    output logic                         al_write,
    output logic [alu_pkg::DATA_W-1:0]   al_result,
    output logic [alu_pkg::FLAG_W-1:0]   al_flags
);
    import alu_pkg::*;

    logic                        is_sub;
    logic                        is_logic;
    logic                        is_byte;
    logic                        cin;
    logic                        h_c, c_b, c_w, c_l;    // nibble, byte, word, long carries
    logic [DATA_W-1:0]           sum;
    logic [DATA_W-1:0]           logic_r;
    logic [DATA_W-1:0]           rslt;
    logic [DATA_W-1:0]           mask;
    logic [$clog2(DATA_W)-1:0]   msb;
    logic                        top_c;
    logic                        rslt_s, rslt_z, rslt_even, rslt_v;

    assign is_sub   = op inside {OP_SUB, OP_SBC, OP_CP, OP_DEC};
    assign is_logic = op inside {OP_AND, OP_OR, OP_XOR};
    assign is_byte  = width == WIDTH_BYTE;
    assign cin      = (op == OP_ADC || op == OP_SBC) ? flags_q[FLAG_C_BIT] : 1'b0;

    always_comb begin
        if (is_sub) begin
            {h_c, sum[3:0]}   = {1'b0, op0[3:0]} - {1'b0, op1[3:0]} - {4'd0, cin};
            {c_b, sum[7:4]}   = {1'b0, op0[7:4]} - {1'b0, op1[7:4]} - {4'd0, h_c};
            {c_w, sum[15:8]}  = {1'b0, op0[15:8]} - {1'b0, op1[15:8]} - {8'd0, c_b};
            {c_l, sum[31:16]} = {1'b0, op0[31:16]} - {1'b0, op1[31:16]} - {16'd0, c_w};
        end else begin
            {h_c, sum[3:0]}   = {1'b0, op0[3:0]} + {1'b0, op1[3:0]} + {4'd0, cin};
            {c_b, sum[7:4]}   = {1'b0, op0[7:4]} + {1'b0, op1[7:4]} + {4'd0, h_c};
            {c_w, sum[15:8]}  = {1'b0, op0[15:8]} + {1'b0, op1[15:8]} + {8'd0, c_b};
            {c_l, sum[31:16]} = {1'b0, op0[31:16]} + {1'b0, op1[31:16]} + {16'd0, c_w};
        end
    end

    always_comb begin
        case (op)
            OP_AND:  logic_r = op0 & op1;
            OP_OR:   logic_r = op0 | op1;
            default: logic_r = op0 ^ op1;
        endcase
    end

    assign rslt = is_logic ? logic_r : sum;

    always_comb begin
        case (width)
            WIDTH_BYTE: begin
                msb   = 5'd7;
                mask  = 32'h0000_00ff;
                top_c = c_b;
            end
            WIDTH_WORD: begin
                msb   = 5'd15;
                mask  = 32'h0000_ffff;
                top_c = c_w;
            end
            default: begin
                msb   = 5'd31;
                mask  = '1;
                top_c = c_l;
            end
        endcase
    end

    assign rslt_s    = rslt[msb];
    assign rslt_z    = (rslt & mask) == '0;
    assign rslt_even = is_byte ? ~^rslt[7:0] : ~^rslt[15:0];
    // carry into top bit xor carry out of it
    assign rslt_v    = op0[msb] ^ op1[msb] ^ sum[msb] ^ top_c;
    assign al_result = rslt;

    always_comb begin
        al_flags = flags_q;
        al_claim = 1'b1;
        al_write = 1'b1;
        case (op)
            OP_ADD, OP_ADC, OP_SUB, OP_SBC, OP_CP: begin
                al_flags[FLAG_S_BIT] = rslt_s;
                al_flags[FLAG_Z_BIT] = rslt_z;
                al_flags[FLAG_H_BIT] = h_c;
                al_flags[FLAG_V_BIT] = rslt_v;
                al_flags[FLAG_N_BIT] = is_sub;
                al_flags[FLAG_C_BIT] = top_c;
                al_write             = op != OP_CP;    // compare is flags only
            end
            OP_INC, OP_DEC: begin
                if (is_byte) begin                    // C never touched
                    al_flags[FLAG_S_BIT] = rslt_s;
                    al_flags[FLAG_Z_BIT] = rslt_z;
                    al_flags[FLAG_H_BIT] = h_c;
                    al_flags[FLAG_V_BIT] = rslt_v;
                    al_flags[FLAG_N_BIT] = is_sub;
                end
            end
            OP_AND, OP_OR, OP_XOR: begin
                al_flags[FLAG_S_BIT] = rslt_s;
                al_flags[FLAG_Z_BIT] = rslt_z;
                al_flags[FLAG_H_BIT] = op == OP_AND;
                al_flags[FLAG_V_BIT] = rslt_even;
                al_flags[FLAG_N_BIT] = 1'b0;
                al_flags[FLAG_C_BIT] = 1'b0;
            end
            default: begin
                al_claim = 1'b0;
                al_write = 1'b0;
            end
        endcase
    end

endmodule

/* verilog/bit_shift_unit.sv */
module bit_shift_unit (
    input  alu_pkg::alu_op_e             op,
    input  logic [alu_pkg::WIDTH_W-1:0]  width,
    input  logic [alu_pkg::DATA_W-1:0]   op0,
    input  logic [alu_pkg::DATA_W-1:0]   op1,
    input  logic [alu_pkg::FLAG_W-1:0]   flags_q,
    output logic                         bs_claim,
    output logic                         bs_write,
    output logic [alu_pkg::DATA_W-1:0]   bs_result,
    output logic [alu_pkg::FLAG_W-1:0]   bs_flags
);
    import alu_pkg::*;

    logic [$clog2(DATA_W)-1:0]   msb_idx;
    logic [DATA_W-1:0]           mask;
    logic                        is_left;
    logic                        op0_s;
    logic                        carry_q;
    logic                        fill_l, fill_r;
    logic [DATA_W-1:0]           shl, shr;
    logic [DATA_W-1:0]           shift_r;
    logic                        shift_c;
    logic                        shift_even;
    logic [BIT_IDX_W-1:0]        idx;
    logic                        bit_val;
    logic [DATA_W-1:0]           bit_r;

    always_comb begin
        case (width)
            WIDTH_LONG: begin
                msb_idx = 5'd31;
                mask    = '1;
            end
            WIDTH_WORD: begin
                msb_idx = 5'd15;
                mask    = 32'h0000_ffff;
            end
            default: begin
                msb_idx = 5'd7;
                mask    = 32'h0000_00ff;
            end
        endcase
    end

    assign op0_s   = op0[msb_idx];
    assign carry_q = flags_q[FLAG_C_BIT];
    assign is_left = op inside {OP_RLC, OP_RL, OP_SLA};
    assign fill_l  = (op == OP_RLC) ? op0_s : (op == OP_RL) ? carry_q : 1'b0;

    always_comb begin
        case (op)
            OP_RRC:  fill_r = op0[0];
            OP_RR:   fill_r = carry_q;
            OP_SRA:  fill_r = op0_s;    // keeps the sign
            default: fill_r = 1'b0;
        endcase
    end

    always_comb begin
        shl          = {op0[DATA_W-2:0], fill_l};
        shr          = {1'b0, op0[DATA_W-1:1]};
        shr[msb_idx] = fill_r;          // fill lands on the top bit of the width
    end

    // bits above the width pass through from op0
    assign shift_r    = (op0 & ~mask) | ((is_left ? shl : shr) & mask);
    assign shift_c    = is_left ? op0_s : op0[0];
    assign shift_even = (width == WIDTH_BYTE) ? ~^shift_r[7:0] : ~^shift_r[15:0];

    assign idx     = op1[BIT_IDX_W-1:0];
    assign bit_val = op0[idx];

    always_comb begin
        bit_r = op0;
        case (op)
            OP_SET, OP_TSET: bit_r[idx] = 1'b1;
            OP_RES:          bit_r[idx] = 1'b0;
            OP_CHG:          bit_r[idx] = ~op0[idx];
            default:         bit_r = op0;
        endcase
    end

    assign bs_result = (op inside {OP_RLC, OP_RRC, OP_RL, OP_RR, OP_SLA, OP_SRA, OP_SRL}) ?
                       shift_r : bit_r;

    always_comb begin
        bs_flags = flags_q;
        bs_claim = 1'b1;
        bs_write = 1'b0;
        case (op)
            OP_RLC, OP_RRC, OP_RL, OP_RR, OP_SLA, OP_SRA, OP_SRL: begin
                bs_write             = 1'b1;
                bs_flags[FLAG_S_BIT] = shift_r[msb_idx];
                bs_flags[FLAG_Z_BIT] = (shift_r & mask) == '0;
                bs_flags[FLAG_H_BIT] = 1'b0;
                bs_flags[FLAG_V_BIT] = shift_even;
                bs_flags[FLAG_N_BIT] = 1'b0;
                bs_flags[FLAG_C_BIT] = shift_c;
            end
            OP_BIT, OP_TSET: begin
                bs_write             = op == OP_TSET;
                bs_flags[FLAG_Z_BIT] = ~bit_val;
                bs_flags[FLAG_H_BIT] = 1'b1;
                bs_flags[FLAG_N_BIT] = 1'b0;
            end
            OP_SET, OP_RES, OP_CHG: bs_write = 1'b1;
            OP_SCF, OP_RCF: begin
                bs_flags[FLAG_C_BIT] = op == OP_SCF;
                bs_flags[FLAG_H_BIT] = 1'b0;
                bs_flags[FLAG_N_BIT] = 1'b0;
            end
            OP_CCF, OP_ZCF, OP_LDCF, OP_ANDCF, OP_ORCF, OP_XORCF: begin
                bs_flags[FLAG_N_BIT] = 1'b0;
                case (op)
                    OP_CCF:   bs_flags[FLAG_C_BIT] = ~carry_q;
                    OP_ZCF:   bs_flags[FLAG_C_BIT] = ~flags_q[FLAG_Z_BIT];
                    OP_LDCF:  bs_flags[FLAG_C_BIT] = bit_val;
                    OP_ANDCF: bs_flags[FLAG_C_BIT] = carry_q & bit_val;
                    OP_ORCF:  bs_flags[FLAG_C_BIT] = carry_q | bit_val;
                    default:  bs_flags[FLAG_C_BIT] = carry_q ^ bit_val;
                endcase
            end
            default: bs_claim = 1'b0;
        endcase
    end

endmodule

/* verilog/tlcs_alu.sv */
module tlcs_alu (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         op_valid,
    input  alu_pkg::alu_op_e             op,
    input  logic [alu_pkg::WIDTH_W-1:0]  width,
    input  logic [alu_pkg::DATA_W-1:0]   op0,
    input  logic [alu_pkg::DATA_W-1:0]   op1,
    output logic [alu_pkg::DATA_W-1:0]   dout,
    output logic [alu_pkg::FLAG_W-1:0]   flags,
    output logic                         result_we
);
    import alu_pkg::*;

    logic                al_claim, al_write;
    logic [DATA_W-1:0]   al_result;
    logic [FLAG_W-1:0]   al_flags;
    logic                bs_claim, bs_write;
    logic [DATA_W-1:0]   bs_result;
    logic [FLAG_W-1:0]   bs_flags;

    arith_logic_unit al_i (
        .op        (op),
        .width     (width),
        .op0       (op0),
        .op1       (op1),
        .flags_q   (flags),     // registered flags fed back
        .al_claim  (al_claim),
        .al_write  (al_write),
        .al_result (al_result),
        .al_flags  (al_flags)
    );

    bit_shift_unit bs_i (
        .op        (op),
        .width     (width),
        .op0       (op0),
        .op1       (op1),
        .flags_q   (flags),
        .bs_claim  (bs_claim),
        .bs_write  (bs_write),
        .bs_result (bs_result),
        .bs_flags  (bs_flags)
    );

    alu_result_reg reg_i (
        .clk       (clk),
        .rst       (rst),
        .op_valid  (op_valid),
        .width     (width),
        .al_claim  (al_claim),
        .al_write  (al_write),
        .al_result (al_result),
        .al_flags  (al_flags),
        .bs_claim  (bs_claim),
        .bs_write  (bs_write),
        .bs_result (bs_result),
        .bs_flags  (bs_flags),
        .dout      (dout),
        .flags     (flags),
        .result_we (result_we)
    );

endmodule
